// ==== alu.f ====
alu_pkg.sv
operand_reg.sv
add_sub_unit.sv
alu_control.sv
alu_datapath.sv
alu.sv
tb_clock_gen.sv
alu_checker.sv
alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f alu.f --top-module alu_tb

./obj_dir/Valu_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

// ==== alu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_tb;

  localparam int W              = alu_pkg::DATA_WIDTH_DEFAULT;
  localparam int N_RANDOM       = 24;
  localparam int IDLE_TIMEOUT   = 50;  // cycles
  localparam int RESULT_TIMEOUT = 100; // a multiply needs about 2W cycles at most
  localparam int NOP_CYCLES     = 20;
  localparam int DRIVE_DELAY    = 10;  // ns after the rising edge

  localparam logic [3:0] VALID_OPS [8] = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB,
      alu_pkg::OP_MUL, alu_pkg::OP_SHL, alu_pkg::OP_SHR, alu_pkg::OP_AND,
      alu_pkg::OP_OR, alu_pkg::OP_XOR};

  typedef struct packed {
    logic [3:0]   op;
    logic [W-1:0] x;
    logic [W-1:0] y;
    logic [W-1:0] hi; // first word of a multiply
    logic [W-1:0] lo; // the only word of every other op
  } row_t;

  logic         clk;
  logic         rst_b;
  logic [W-1:0] x;
  logic [W-1:0] y;
  alu_pkg::op_e op;
  logic [W-1:0] z;
  logic         idle;
  logic         result_ready;

  row_t rows[$];
  int   pass_count;
  int   fail_count;
  bit   timed_out;
  bit   test_ok;

  tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.clk(clk));

  alu #(.W(W)) i_alu (
    .clk          (clk),
    .rst_b        (rst_b),
    .x            (x),
    .y            (y),
    .op           (op),
    .z            (z),
    .idle         (idle),
    .result_ready (result_ready)
  );

  bind alu_control alu_checker u_checker (
    .clk          (clk),
    .rst_b        (rst_b),
    .idle         (idle),
    .result_ready (result_ready),
    .state        (state_q),
    .op_latched   (op_q)
  );

  function automatic bit is_valid_op(input logic [3:0] code);
    return code inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_MUL, alu_pkg::OP_SHL,
                        alu_pkg::OP_SHR, alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR};
  endfunction

  function automatic row_t fixed_row(input logic [3:0] code, input logic [W-1:0] a,
                                     input logic [W-1:0] b, input logic [W-1:0] hi,
                                     input logic [W-1:0] lo);
    row_t r;
    r.op = code;
    r.x  = a;
    r.y  = b;
    r.hi = hi;
    r.lo = lo;
    return r;
  endfunction

  // behavioral model of every op
  function automatic row_t model_row(input logic [3:0] code, input logic [W-1:0] a,
                                     input logic [W-1:0] b);
    row_t           r;
    logic [2*W-1:0] prod;
    r    = '0;
    r.op = code;
    r.x  = a;
    r.y  = b;
    prod = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b}; // signed product from sign-extended operands
    case (code)
      alu_pkg::OP_ADD: r.lo = a + b;
      alu_pkg::OP_SUB: r.lo = a - b;
      alu_pkg::OP_MUL: begin
        r.hi = prod[2*W-1:W];
        r.lo = prod[W-1:0];
      end
      alu_pkg::OP_SHL: r.lo = {a[W-2:0], 1'b0};
      alu_pkg::OP_SHR: r.lo = {1'b0, a[W-1:1]};
      alu_pkg::OP_AND: r.lo = a & b;
      alu_pkg::OP_OR:  r.lo = a | b;
      alu_pkg::OP_XOR: r.lo = a ^ b;
      default:         r.lo = '0;
    endcase
    return r;
  endfunction

  task automatic load_fixed_rows();
    rows.push_back(fixed_row(alu_pkg::OP_NONE, 16'h1234, 16'h5678, 16'h0000, 16'h0000));
    rows.push_back(fixed_row(4'd4,  16'h1234, 16'h5678, 16'h0000, 16'h0000)); // unused
    rows.push_back(fixed_row(4'd12, 16'hffff, 16'hffff, 16'h0000, 16'h0000));
    rows.push_back(fixed_row(alu_pkg::OP_ADD, 16'h1234, 16'h4321, 16'h0000, 16'h5555));
    rows.push_back(fixed_row(alu_pkg::OP_ADD, 16'hffff, 16'h0001, 16'h0000, 16'h0000));
    rows.push_back(fixed_row(alu_pkg::OP_SUB, 16'h0005, 16'h0007, 16'h0000, 16'hfffe));
    rows.push_back(fixed_row(alu_pkg::OP_SUB, 16'h8000, 16'h0001, 16'h0000, 16'h7fff));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h0007, 16'hfffd, 16'hffff, 16'hffeb));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h8000, 16'h8000, 16'h4000, 16'h0000));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h8000, 16'h7fff, 16'hc000, 16'h8000));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h7fff, 16'h7fff, 16'h3fff, 16'h0001));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'hffff, 16'hffff, 16'h0000, 16'h0001));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h0000, 16'h1234, 16'h0000, 16'h0000));
    rows.push_back(fixed_row(alu_pkg::OP_MUL, 16'h0123, 16'h0010, 16'h0000, 16'h1230));
    rows.push_back(fixed_row(alu_pkg::OP_SHL, 16'h8001, 16'h0000, 16'h0000, 16'h0002));
    rows.push_back(fixed_row(alu_pkg::OP_SHR, 16'h8001, 16'h0000, 16'h0000, 16'h4000));
    rows.push_back(fixed_row(alu_pkg::OP_SHL, 16'h5a5a, 16'hffff, 16'h0000, 16'hb4b4));
    rows.push_back(fixed_row(alu_pkg::OP_SHR, 16'ha5a5, 16'hffff, 16'h0000, 16'h52d2));
    rows.push_back(fixed_row(alu_pkg::OP_AND, 16'hf0f0, 16'hff00, 16'h0000, 16'hf000));
    rows.push_back(fixed_row(alu_pkg::OP_OR,  16'hf0f0, 16'h0f0f, 16'h0000, 16'hffff));
    rows.push_back(fixed_row(alu_pkg::OP_XOR, 16'haaaa, 16'hffff, 16'h0000, 16'h5555));
    rows.push_back(fixed_row(alu_pkg::OP_XOR, 16'h1234, 16'h1234, 16'h0000, 16'h0000));
  endtask

  task automatic add_random_rows();
    logic [3:0] code;
    for (int i = 0; i < N_RANDOM; i++) begin
      code = VALID_OPS[$urandom_range(0, 7)];
      rows.push_back(model_row(code, W'($urandom()), W'($urandom())));
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: error", name);
    end
  endtask

  task automatic wait_for_idle(output bit ok);
    int n;
    n = 0;
    while (!idle && n < IDLE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = idle;
  endtask

  task automatic wait_for_result(output bit ok, output int cycles);
    cycles = 0;
    while (!result_ready && cycles < RESULT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = result_ready;
  endtask

  task automatic apply_nop(input row_t r);
    bit stayed;
    stayed = 1'b1;
    @(posedge clk);
    #(DRIVE_DELAY);
    op = alu_pkg::op_e'(r.op);
    x  = r.x;
    y  = r.y;
    repeat (NOP_CYCLES) begin
      @(negedge clk);
      if (!idle || result_ready) begin
        stayed = 1'b0;
      end
    end
    assert (stayed) else begin
      $display("[FAIL] %0d ns: op %0d left the idle state", $time, r.op);
      test_ok = 1'b0;
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    op = alu_pkg::OP_NONE;
  endtask

  task automatic apply_op(input row_t r);
    bit ok;
    int cycles;
    @(posedge clk);
    #(DRIVE_DELAY);
    op = alu_pkg::op_e'(r.op);
    x  = r.x;
    y  = r.y;
    @(posedge clk); // accepting edge
    #(DRIVE_DELAY);
    op = alu_pkg::OP_NONE;
    x  = ~r.x; // already latched
    wait_for_result(ok, cycles);
    if (!ok) begin
      $display("timeout: no result_ready within %0d cycles for op %0d", RESULT_TIMEOUT, r.op);
      timed_out = 1'b1;
      test_ok   = 1'b0;
    end else begin
      if (r.op == alu_pkg::OP_MUL) begin
        assert (z === r.hi) else begin
          $display("[FAIL] %0d ns: high word %h, expected %h", $time, z, r.hi);
          test_ok = 1'b0;
        end
        @(negedge clk);
        assert (result_ready === 1'b1 && z === r.lo) else begin
          $display("[FAIL] %0d ns: low word result_ready=%b z=%h, expected 1 and %h",
                   $time, result_ready, z, r.lo);
          test_ok = 1'b0;
        end
      end else begin
        // third sampled cycle is two edges after acceptance
        assert (cycles == 3) else begin
          $display("[FAIL] %0d ns: result after %0d cycles, expected 2", $time, cycles - 1);
          test_ok = 1'b0;
        end
        assert (z === r.lo) else begin
          $display("[FAIL] %0d ns: z %h, expected %h", $time, z, r.lo);
          test_ok = 1'b0;
        end
      end
      @(negedge clk);
      assert (idle === 1'b1 && result_ready === 1'b0) else begin
        $display("[FAIL] %0d ns: after result idle=%b result_ready=%b, expected 1 and 0",
                 $time, idle, result_ready);
        test_ok = 1'b0;
      end
    end
  endtask

  task automatic run_row(input int idx, input row_t r);
    bit ok;
    test_ok = 1'b1;
    wait_for_idle(ok);
    if (!ok) begin
      $display("timeout: DUT not idle within %0d cycles before test %0d", IDLE_TIMEOUT, idx);
      timed_out = 1'b1;
      test_ok   = 1'b0;
    end else if (is_valid_op(r.op)) begin
      apply_op(r);
    end else begin
      apply_nop(r);
    end
    report_test($sformatf("test %0d op %0d x %h y %h", idx, r.op, r.x, r.y), test_ok);
  endtask

  initial begin
    void'($urandom(32'h941e_b798));
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    rst_b      = 1'b0;
    op         = alu_pkg::OP_NONE;
    x          = '0;
    y          = '0;
    load_fixed_rows();
    add_random_rows();
    repeat (10) @(posedge clk);
    #(DRIVE_DELAY);
    rst_b = 1'b1;

    @(negedge clk);
    test_ok = 1'b1;
    assert (idle === 1'b1 && result_ready === 1'b0) else begin
      $display("[FAIL] %0d ns: after reset idle=%b result_ready=%b, expected 1 and 0",
               $time, idle, result_ready);
      test_ok = 1'b0;
    end
    report_test("reset state", test_ok);

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      run_row(i, rows[i]);
    end

    $display("%0d tests passed, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== alu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_checker (
  input wire logic         clk,
  input wire logic         rst_b,
  input wire logic         idle,
  input wire logic         result_ready,
  input wire logic [6:0]   state,
  input wire alu_pkg::op_e op_latched
);

  a_idle_not_ready : assert property (@(posedge clk) disable iff (!rst_b)
    !(idle && result_ready))
    else $error("idle and result_ready are high in the same cycle");

  a_state_onehot : assert property (@(posedge clk) disable iff (!rst_b)
    $onehot(state))
    else $error("state vector %b is not one-hot", state);

  // product is shown as high word then low word
  a_mul_second_word : assert property (@(posedge clk) disable iff (!rst_b)
    ($rose(result_ready) && op_latched == alu_pkg::OP_MUL) |=> result_ready)
    else $error("result_ready of a multiply dropped after the high word");

  a_ready_max_two : assert property (@(posedge clk) disable iff (!rst_b)
    (result_ready && $past(result_ready)) |=> !result_ready)
    else $error("result_ready stayed high for more than two cycles");

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  localparam int HALF_NS = PERIOD_NS / 2;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_NS);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu #(
  parameter int W = alu_pkg::DATA_WIDTH_DEFAULT
) (
  input  wire logic         clk,
  input  wire logic         rst_b,
  input  wire logic [W-1:0] x,
  input  wire logic [W-1:0] y,
  input  wire alu_pkg::op_e op,
  output logic      [W-1:0] z,
  output logic              idle,
  output logic              result_ready
);

  logic               load_operands;
  logic               clear_a;
  logic               load_a;
  alu_pkg::a_src_e    a_src;
  alu_pkg::logic_fn_e logic_fn;
  logic               use_q;
  logic               subtract;
  logic               shift_left;
  logic               shift_right;
  logic               count_step;
  logic               out_q;
  logic               q_lsb;
  logic               q_guard;
  logic               count_done;

  alu_control u_control (
    .clk           (clk),
    .rst_b         (rst_b),
    .op            (op),
    .q_lsb         (q_lsb),
    .q_guard       (q_guard),
    .count_done    (count_done),
    .idle          (idle),
    .load_operands (load_operands),
    .clear_a       (clear_a),
    .load_a        (load_a),
    .a_src         (a_src),
    .logic_fn      (logic_fn),
    .use_q         (use_q),
    .subtract      (subtract),
    .shift_left    (shift_left),
    .shift_right   (shift_right),
    .count_step    (count_step),
    .out_q         (out_q),
    .result_ready  (result_ready)
  );

  alu_datapath #(.W(W)) u_datapath (
    .clk           (clk),
    .rst_b         (rst_b),
    .x             (x),
    .y             (y),
    .load_operands (load_operands),
    .clear_a       (clear_a),
    .load_a        (load_a),
    .a_src         (a_src),
    .logic_fn      (logic_fn),
    .use_q         (use_q),
    .subtract      (subtract),
    .shift_left    (shift_left),
    .shift_right   (shift_right),
    .count_step    (count_step),
    .out_q         (out_q),
    .q_lsb         (q_lsb),
    .q_guard       (q_guard),
    .count_done    (count_done),
    .z             (z)
  );

endmodule

`default_nettype wire

// ==== alu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_datapath #(
  parameter int W = alu_pkg::DATA_WIDTH_DEFAULT
) (
  input  wire logic               clk,
  input  wire logic               rst_b,
  input  wire logic [W-1:0]       x,
  input  wire logic [W-1:0]       y,
  input  wire logic               load_operands,
  input  wire logic               clear_a,
  input  wire logic               load_a,
  input  wire alu_pkg::a_src_e    a_src,
  input  wire alu_pkg::logic_fn_e logic_fn,
  input  wire logic               use_q,
  input  wire logic               subtract,
  input  wire logic               shift_left,
  input  wire logic               shift_right,
  input  wire logic               count_step,
  input  wire logic               out_q,
  output logic                    q_lsb,
  output logic                    q_guard,
  output logic                    count_done,
  output logic      [W-1:0]       z
);

  typedef logic [W-1:0] word_t;
  typedef logic [W:0]   qword_t; // bit 0 is the booth guard

  localparam int CNT_W = $clog2(W) + 1; // top bit marks W steps, W a power of two

  word_t            a_q;
  word_t            m_q;
  qword_t           q_q;
  word_t            q_hi;
  word_t            adder_a;
  word_t            sum;
  word_t            logic_out;
  word_t            a_d;
  logic             add_ovf;
  logic             a_ovf_q;
  logic             a_shift_in;
  logic             q_shift_in;
  logic [CNT_W-1:0] cnt_q;

  assign q_hi    = q_q[W:1];
  assign adder_a = use_q ? q_hi : a_q;

  add_sub_unit #(.W(W)) u_add_sub (
    .a        (adder_a),
    .b        (m_q),
    .subtract (subtract),
    .sum      (sum)
  );

  // signed overflow, b sign taken after inversion
  assign add_ovf = ~(adder_a[W-1] ^ m_q[W-1] ^ subtract) & (adder_a[W-1] ^ sum[W-1]);

  // booth A +- M can wrap, the following shift needs the true sign
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      a_ovf_q <= 1'b0;
    end else if (load_a) begin
      a_ovf_q <= add_ovf & (a_src == alu_pkg::A_FROM_ADDER);
    end else if (clear_a | shift_right) begin
      a_ovf_q <= 1'b0;
    end
  end

  always_comb begin
    case (logic_fn)
      alu_pkg::LF_OR:  logic_out = q_hi | m_q;
      alu_pkg::LF_XOR: logic_out = q_hi ^ m_q;
      default:         logic_out = q_hi & m_q;
    endcase
  end

  assign a_d        = (a_src == alu_pkg::A_FROM_LOGIC) ? logic_out : sum;
  assign a_shift_in = a_q[W-1] ^ a_ovf_q;   // arithmetic shift of A
  assign q_shift_in = shift_right & a_q[0]; // left shift fills zero

  operand_reg #(.payload_t(word_t)) u_a_reg (
    .clk         (clk),
    .rst_b       (rst_b),
    .load        (load_a),
    .clear       (clear_a),
    .shift_left  (1'b0),
    .shift_right (shift_right),
    .shift_in    (a_shift_in),
    .d           (a_d),
    .q           (a_q)
  );

  operand_reg #(.payload_t(qword_t)) u_q_reg (
    .clk         (clk),
    .rst_b       (rst_b),
    .load        (load_operands),
    .clear       (1'b0),
    .shift_left  (shift_left),
    .shift_right (shift_right),
    .shift_in    (q_shift_in),
    .d           ({x, 1'b0}),
    .q           (q_q)
  );

  // M follows y every cycle
  operand_reg #(.payload_t(word_t)) u_m_reg (
    .clk         (clk),
    .rst_b       (rst_b),
    .load        (1'b1),
    .clear       (1'b0),
    .shift_left  (1'b0),
    .shift_right (1'b0),
    .shift_in    (1'b0),
    .d           (y),
    .q           (m_q)
  );

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (load_operands) begin
      cnt_q <= '0;
    end else if (count_step) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  assign q_lsb      = q_q[1];
  assign q_guard    = q_q[0];
  assign count_done = cnt_q[CNT_W-1];
  assign z          = out_q ? q_hi : a_q; // low word of product or shift result

endmodule

`default_nettype wire

// ==== alu_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_control (
  input  wire logic           clk,
  input  wire logic           rst_b,
  input  wire alu_pkg::op_e   op,
  input  wire logic           q_lsb,
  input  wire logic           q_guard,
  input  wire logic           count_done,
  output logic                idle,
  output logic                load_operands,
  output logic                clear_a,
  output logic                load_a,
  output alu_pkg::a_src_e     a_src,
  output alu_pkg::logic_fn_e  logic_fn,
  output logic                use_q,
  output logic                subtract,
  output logic                shift_left,
  output logic                shift_right,
  output logic                count_step,
  output logic                out_q,
  output logic                result_ready
);

  localparam int STATE_COUNT = 7;
  localparam logic [STATE_COUNT-1:0] WAIT_ONEHOT = STATE_COUNT'(1) << alu_pkg::ST_WAIT;

  logic [STATE_COUNT-1:0] state_q;
  logic [STATE_COUNT-1:0] state_d;
  alu_pkg::op_e           op_q;

  logic accept;
  logic is_add;
  logic is_sub;
  logic is_mul;
  logic is_shl;
  logic is_shr;
  logic is_logic;
  logic booth_add;
  logic booth_sub;
  logic booth_shift;
  logic decide;

  // unused codes never leave WAIT
  assign accept = state_q[alu_pkg::ST_WAIT] & (op inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB,
      alu_pkg::OP_MUL, alu_pkg::OP_SHL, alu_pkg::OP_SHR, alu_pkg::OP_AND, alu_pkg::OP_OR,
      alu_pkg::OP_XOR});

  assign is_add   = (op_q == alu_pkg::OP_ADD);
  assign is_sub   = (op_q == alu_pkg::OP_SUB);
  assign is_mul   = (op_q == alu_pkg::OP_MUL);
  assign is_shl   = (op_q == alu_pkg::OP_SHL);
  assign is_shr   = (op_q == alu_pkg::OP_SHR);
  assign is_logic = (op_q == alu_pkg::OP_AND) | (op_q == alu_pkg::OP_OR) |
                    (op_q == alu_pkg::OP_XOR);

  assign booth_add   = ~q_lsb & q_guard;  // pair 01
  assign booth_sub   = q_lsb & ~q_guard;  // pair 10
  assign booth_shift = ~(booth_add | booth_sub);

  // booth step picked in INIT and after every shift until W shifts are done
  assign decide = is_mul & (state_q[alu_pkg::ST_INIT] |
                            (state_q[alu_pkg::ST_SHIFT] & ~count_done));

  // one-hot next state
  assign state_d[alu_pkg::ST_WAIT] = (state_q[alu_pkg::ST_WAIT] & ~accept) |
                                     (state_q[alu_pkg::ST_OUT_A] & ~is_mul) |
                                     (state_q[alu_pkg::ST_OUT_Q] & (is_mul | is_shl | is_shr));
  assign state_d[alu_pkg::ST_INIT] = accept;
  assign state_d[alu_pkg::ST_ADD]  = (state_q[alu_pkg::ST_INIT] & is_add) |
                                     (decide & booth_add);
  assign state_d[alu_pkg::ST_SUB]  = (state_q[alu_pkg::ST_INIT] & is_sub) |
                                     (decide & booth_sub);
  assign state_d[alu_pkg::ST_SHIFT] = (state_q[alu_pkg::ST_INIT] & (is_shl | is_shr)) |
                                      (decide & booth_shift) |
                                      (is_mul & (state_q[alu_pkg::ST_ADD] |
                                                 state_q[alu_pkg::ST_SUB]));
  assign state_d[alu_pkg::ST_OUT_A] = (state_q[alu_pkg::ST_ADD] & is_add) |
                                      (state_q[alu_pkg::ST_SUB] & is_sub) |
                                      (state_q[alu_pkg::ST_SHIFT] & is_mul & count_done) |
                                      (state_q[alu_pkg::ST_OUT_Q] & is_logic);
  assign state_d[alu_pkg::ST_OUT_Q] = (state_q[alu_pkg::ST_INIT] & is_logic) |
                                      (state_q[alu_pkg::ST_OUT_A] & is_mul) |
                                      (state_q[alu_pkg::ST_SHIFT] & (is_shl | is_shr));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= WAIT_ONEHOT;
      op_q    <= alu_pkg::OP_NONE;
    end else begin
      state_q <= state_d;
      if (state_q[alu_pkg::ST_WAIT]) begin
        op_q <= op; // held for the whole operation
      end
    end
  end

  // strobes act on the edge that leaves the current state
  assign idle          = state_q[alu_pkg::ST_WAIT];
  assign load_operands = accept;
  assign clear_a       = accept;
  assign load_a        = (state_q[alu_pkg::ST_INIT] & (is_add | is_sub | is_logic)) |
                         (decide & (booth_add | booth_sub));
  assign a_src         = is_logic ? alu_pkg::A_FROM_LOGIC : alu_pkg::A_FROM_ADDER;
  assign use_q         = state_q[alu_pkg::ST_INIT] & (is_add | is_sub);
  assign subtract      = (state_q[alu_pkg::ST_INIT] & is_sub) | (decide & booth_sub);
  assign shift_left    = state_q[alu_pkg::ST_INIT] & is_shl;
  assign count_step    = (decide & booth_shift) |
                         (is_mul & (state_q[alu_pkg::ST_ADD] | state_q[alu_pkg::ST_SUB]));
  assign shift_right   = (state_q[alu_pkg::ST_INIT] & is_shr) | count_step;
  assign out_q         = state_q[alu_pkg::ST_OUT_Q] & (is_mul | is_shl | is_shr);
  assign result_ready  = (state_q[alu_pkg::ST_OUT_A] & (is_add | is_sub | is_mul | is_logic)) |
                         out_q;

  always_comb begin
    case (op_q)
      alu_pkg::OP_OR:  logic_fn = alu_pkg::LF_OR;
      alu_pkg::OP_XOR: logic_fn = alu_pkg::LF_XOR;
      default:         logic_fn = alu_pkg::LF_AND;
    endcase
  end

endmodule

`default_nettype wire

// ==== add_sub_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module add_sub_unit #(
  parameter int W = alu_pkg::DATA_WIDTH_DEFAULT
) (
  input  wire logic [W-1:0] a,
  input  wire logic [W-1:0] b,
  input  wire logic         subtract,
  output logic      [W-1:0] sum
);

  logic [W-1:0] b_eff;
  logic [W-1:0] carry; // carry into each bit, carry out of the msb is dropped

  // a - b = a + ~b + 1
  assign b_eff    = b ^ {W{subtract}};
  assign carry[0] = subtract;

  for (genvar i = 0; i < W; i++) begin : g_fa
    assign sum[i] = a[i] ^ b_eff[i] ^ carry[i];

    if (i < W - 1) begin : g_carry
      assign carry[i+1] = (a[i] & b_eff[i]) | (carry[i] & (a[i] ^ b_eff[i]));
    end
  end

endmodule

`default_nettype wire

// ==== operand_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_reg #(
  parameter type payload_t = logic [alu_pkg::DATA_WIDTH_DEFAULT-1:0]
) (
  input  wire logic clk,
  input  wire logic rst_b,
  input  wire logic load,
  input  wire logic clear,
  input  wire logic shift_left,
  input  wire logic shift_right,
  input  wire logic shift_in,
  input  wire payload_t d,
  output payload_t q
);

  localparam int N = $bits(payload_t);

  payload_t q_next;

  // priority is clear, load, left shift, right shift
  always_comb begin
    q_next = q;
    if (clear) begin
      q_next = '0;
    end else if (load) begin
      q_next = d;
    end else if (shift_left) begin
      q_next = {q[N-2:0], shift_in}; // vacated lsb takes shift_in
    end else if (shift_right) begin
      q_next = {shift_in, q[N-1:1]}; // vacated msb takes shift_in
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      q <= '0;
    end else begin
      q <= q_next;
    end
  end

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int DATA_WIDTH_DEFAULT = 16;

  // codes 4 and 10..15 are treated as OP_NONE
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_MUL  = 4'd3, // booth, high word then low word
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_AND  = 4'd7,
    OP_OR   = 4'd8,
    OP_XOR  = 4'd9
  } op_e;

  typedef enum logic [1:0] {
    LF_AND = 2'd0,
    LF_OR  = 2'd1,
    LF_XOR = 2'd2
  } logic_fn_e;

  typedef enum logic {
    A_FROM_ADDER = 1'b0,
    A_FROM_LOGIC = 1'b1
  } a_src_e;

  // bit positions in the one-hot state vector
  typedef enum int unsigned {
    ST_WAIT  = 0,
    ST_INIT  = 1,
    ST_ADD   = 2,
    ST_SUB   = 3,
    ST_SHIFT = 4,
    ST_OUT_A = 5,
    ST_OUT_Q = 6
  } state_idx_e;

endpackage

`default_nettype wire
